//--- filelist.f
+incdir+include
design/cpuPkg.sv
design/addrCtrlIf.sv
design/addressingDecoder.sv
design/cycleSequencer.sv
design/addressDatapath.sv
design/addressUnit.sv
testbench/addressChecker.sv
testbench/addressUnitTb.sv

//--- run.sh
#!/bin/sh
# Build the simulation with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module addressUnitTb -o addressUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/addressUnitSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- testbench/addressUnitTb.sv
module addressUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS = 400;
    localparam int CLK_PERIOD = 100;

    logic              clk;
    logic              reset;
    logic              start;
    cpuPkg::addrMode_t mode;
    logic [7:0]        dataIn;
    logic              loadX;
    logic              loadY;
    logic [15:0]       address;
    logic [15:0]       pc;
    logic              busy;
    logic              done;
    int                valueErrors;
    int                timingErrors;
    int                stallErrors;
    logic [31:0]       rngState;

    addressUnit DUT (.*);

    addressChecker monitor (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    task automatic printCounts();
        $display("Errors: value %0d, timing %0d, stalled %0d",
                 valueErrors, timingErrors, stallErrors);
    endtask

    // Runs from the start edge to done, with noise on the inputs while busy
    task automatic waitForDone();
        logic [31:0] r;
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < 8) begin
            nextRandom(r);
            dataIn = r[15:8];
            start = (r[17:16] == 2'b00);
            mode = cpuPkg::addrMode_t'(r[20:18]);
            loadX = (r[23:21] == 3'b000);
            loadY = (r[26:24] == 3'b000);
            waited++;
            @(negedge clk);
        end
        if (!done) begin
            $display("Sequence stalled: done did not arrive within 8 cycles of a start");
            stallErrors++;
        end
        nextRandom(r);
        dataIn = r[15:8];
        start = 1'b0;
        loadX = 1'b0;
        loadY = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_OPS * 6 * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        printCounts();
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rngState = 32'd46111;
        stallErrors = 0;
        reset = 1'b1;
        start = 1'b0;
        mode = cpuPkg::IMPLIED;
        dataIn = 8'h00;
        loadX = 1'b0;
        loadY = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int op = 0; op < NUM_OPS; op++) begin
            nextRandom(r);
            @(negedge clk);
            dataIn = r[15:8];
            start = 1'b0;
            loadX = 1'b0;
            loadY = 1'b0;
            case (r[1:0])
                2'd0: loadX = 1'b1;
                2'd1: loadY = 1'b1;
                default: begin
                    start = 1'b1;
                    mode = cpuPkg::addrMode_t'(r[4:2]);
                    waitForDone();
                end
            endcase
        end
        @(negedge clk);
        loadX = 1'b0;
        loadY = 1'b0;
        repeat (2) @(negedge clk);

        printCounts();
        if (valueErrors + timingErrors + stallErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end
endmodule

//--- testbench/addressChecker.sv
`include "addrFlags_defs.svh"

module addressChecker (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpuPkg::addrMode_t mode,
    input  logic [7:0]        dataIn,
    input  logic              loadX,
    input  logic              loadY,
    input  logic [15:0]       address,
    input  logic [15:0]       pc,
    input  logic              busy,
    input  logic              done,
    output int                valueErrors,
    output int                timingErrors
);
    timeunit 1ns;
    timeprecision 1ps;

    cpuPkg::addrMode_t modelMode;
    cpuPkg::addrWord_t expAddr;
    cpuPkg::addrWord_t actAddr;
    logic [15:0]       modelPc;
    logic [7:0]        modelX;
    logic [7:0]        modelY;
    logic [7:0]        d0;
    logic [7:0]        d1;
    logic              modelBusy;
    logic              expDone = 1'b0;
    logic              resetSeen = 1'b0;
    int                stepCount;
    int                valueCount = 0;
    int                timingCount = 0;

    assign valueErrors = valueCount;
    assign timingErrors = timingCount;
    assign actAddr.word = address;

    function automatic int stepsFor(input cpuPkg::addrMode_t m);
        case (m)
            cpuPkg::IMPLIED, cpuPkg::IMMEDIATE, cpuPkg::ZPG: return 1;
            cpuPkg::ZPG_X, cpuPkg::ZPG_Y, cpuPkg::ABSOLUTE: return 2;
            default: return 3;
        endcase
    endfunction

    function automatic string nameOf(input cpuPkg::addrMode_t m);
        case (m)
            cpuPkg::IMPLIED: return "implied";
            cpuPkg::IMMEDIATE: return "immediate";
            cpuPkg::ZPG: return "zero page";
            cpuPkg::ZPG_X: return "zero page X";
            cpuPkg::ZPG_Y: return "zero page Y";
            cpuPkg::ABSOLUTE: return "absolute";
            cpuPkg::ABS_X: return "absolute X";
            default: return "absolute Y";
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            valueCount++;
        end
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            timingCount++;
        end
    endtask

    // Expected address and PC once the mode has seen all its bytes
    task automatic finishMode();
        case (modelMode)
            cpuPkg::IMMEDIATE: begin
                expAddr.word = modelPc;
                modelPc = modelPc + 16'd1;
            end
            cpuPkg::ZPG: begin
                expAddr.bytes.high = 8'h00;
                expAddr.bytes.low = d0;
            end
            cpuPkg::ZPG_X, cpuPkg::ZPG_Y: begin
                expAddr.bytes.high = 8'h00;
                expAddr.bytes.low = d0 + ((modelMode == cpuPkg::ZPG_X) ? modelX : modelY);
            end
            cpuPkg::ABSOLUTE, cpuPkg::ABS_X, cpuPkg::ABS_Y: begin
                expAddr.bytes.high = d1;
                expAddr.bytes.low = d0;
                if (modelMode == cpuPkg::ABS_X) begin
                    expAddr.word = expAddr.word + {8'h00, modelX};
                end else if (modelMode == cpuPkg::ABS_Y) begin
                    expAddr.word = expAddr.word + {8'h00, modelY};
                end
                modelPc = modelPc + 16'd1;
            end
            default: begin
            end
        endcase
    endtask

    always @(posedge clk) begin
        expDone = 1'b0;
        if (reset) begin
            modelBusy = 1'b0;
            modelPc = `PC_RESET;
            modelX = 8'h00;
            modelY = 8'h00;
            expAddr.word = 16'h0000;
            stepCount = 0;
            resetSeen = 1'b1;
        end else if (!modelBusy) begin
            if (loadX) begin
                modelX = dataIn;
            end
            if (loadY) begin
                modelY = dataIn;
            end
            if (start) begin
                modelBusy = 1'b1;
                modelMode = mode;
                stepCount = 0;
            end
        end else begin
            stepCount++;
            if (stepCount == 1) begin
                d0 = dataIn;
            end
            if (stepCount == 2) begin
                d1 = dataIn;
            end
            if (stepCount == stepsFor(modelMode)) begin
                finishMode();
                modelBusy = 1'b0;
                expDone = 1'b1;
            end
        end
    end

    // Outputs are stable half a cycle after the edge
    always @(negedge clk) begin
        if (resetSeen) begin
            if (reset) begin
                compareValue("reset pc", `PC_RESET, pc);
                compareValue("reset address", 16'h0000, address);
                compareFlag("reset busy", 1'b0, busy);
                compareFlag("reset done", 1'b0, done);
            end else begin
                compareFlag("done timing", expDone, done);
                compareFlag("busy timing", modelBusy, busy);
                if (done) begin
                    compareValue({nameOf(modelMode), " address high"},
                                 {8'h00, expAddr.bytes.high}, {8'h00, actAddr.bytes.high});
                    compareValue({nameOf(modelMode), " address low"},
                                 {8'h00, expAddr.bytes.low}, {8'h00, actAddr.bytes.low});
                    compareValue({nameOf(modelMode), " pc"}, modelPc, pc);
                end
            end
        end
    end
endmodule

//--- design/addressUnit.sv
module addressUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpuPkg::addrMode_t mode,
    input  logic [7:0]        dataIn,
    input  logic              loadX,
    input  logic              loadY,
    output logic [15:0]       address,
    output logic [15:0]       pc,
    output logic              busy,
    output logic              done
);
    addrCtrlIf ctrlBus ();

    cycleSequencer sequencer (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .modeIn (mode),
        .ctrl   (ctrlBus.seq),
        .busy   (busy),
        .done   (done)
    );

    addressingDecoder decoder (
        .ctrl (ctrlBus.dec)
    );

    addressDatapath datapath (
        .clk     (clk),
        .reset   (reset),
        .dataIn  (dataIn),
        .loadX   (loadX),
        .loadY   (loadY),
        .idle    (!busy),
        .ctrl    (ctrlBus.dp),
        .address (address),
        .pc      (pc)
    );
endmodule

//--- design/addressDatapath.sv
`include "addrFlags_defs.svh"

module addressDatapath (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  dataIn,
    input  logic        loadX,
    input  logic        loadY,
    input  logic        idle,
    addrCtrlIf.dp       ctrl,
    output logic [15:0] address,
    output logic [15:0] pc
);
    cpuPkg::addrWord_t pcReg;
    cpuPkg::addrWord_t abReg;
    logic [7:0] xReg;
    logic [7:0] yReg;
    logic [7:0] aluReg;
    logic       carryReg;
    logic [7:0] db;
    logic [7:0] sb;
    logic [7:0] adl;
    logic [7:0] adh;
    logic [7:0] inputA;
    logic [7:0] inputB;
    logic       carryIn;
    logic [8:0] sum;

    assign db = ctrl.flags[`SET_DB_TO_DATA] ? dataIn : 8'h00;

    always_comb begin
        if (ctrl.flags[`SET_SB_TO_X]) begin
            sb = xReg;
        end else if (ctrl.flags[`SET_SB_TO_Y]) begin
            sb = yReg;
        end else if (ctrl.flags[`SET_SB_TO_ALU]) begin
            sb = aluReg;
        end else if (ctrl.flags[`SET_SB_TO_DB]) begin
            sb = db;
        end else begin
            sb = 8'h00;
        end
    end

    // 8-bit adder with optional stored carry
    assign inputA = ctrl.flags[`SET_INPUT_A_TO_SB] ? sb : 8'h00;
    assign inputB = ctrl.flags[`SET_INPUT_B_TO_DB] ? db : 8'h00;
    assign carryIn = ctrl.flags[`ADD_CARRY] & carryReg;
    assign sum = {1'b0, inputA} + {1'b0, inputB} + {8'h00, carryIn};

    always_comb begin
        if (ctrl.flags[`SET_ADL_TO_DATA]) begin
            adl = dataIn;
        end else if (ctrl.flags[`SET_ADL_TO_ALU]) begin
            adl = aluReg;
        end else if (ctrl.flags[`SET_ADL_TO_PCL]) begin
            adl = pcReg.bytes.low;
        end else begin
            adl = 8'h00;
        end
    end

    always_comb begin
        if (ctrl.flags[`SET_ADH_LOW]) begin
            adh = 8'h00;
        end else if (ctrl.flags[`SET_ADH_TO_SB]) begin
            adh = sb;
        end else if (ctrl.flags[`SET_ADH_TO_PCH]) begin
            adh = pcReg.bytes.high;
        end else begin
            adh = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcReg.word <= `PC_RESET;
            abReg.word <= 16'h0000;
            xReg <= 8'h00;
            yReg <= 8'h00;
        end else begin
            if (ctrl.flags[`PC_INC]) begin
                pcReg.word <= pcReg.word + 16'd1;
            end
            if (ctrl.flags[`LOAD_PC_AB]) begin
                abReg.word <= pcReg.word;
            end else begin
                if (ctrl.flags[`LOAD_ABL]) begin
                    abReg.bytes.low <= adl;
                end
                if (ctrl.flags[`LOAD_ABH]) begin
                    abReg.bytes.high <= adh;
                end
            end
            // Index loads only between sequences
            if (idle && loadX) begin
                xReg <= dataIn;
            end
            if (idle && loadY) begin
                yReg <= dataIn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.flags[`ALU_ADD]) begin
            aluReg <= sum[7:0];
            carryReg <= sum[8];
        end else if (ctrl.flags[`PC_INC]) begin
            // Absolute mode parks its low byte here
            aluReg <= inputB;
        end
    end

    assign address = abReg.word;
    assign pc = pcReg.word;

    adlOneSource: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.flags[`SET_ADL_TO_DATA], ctrl.flags[`SET_ADL_TO_ALU],
                  ctrl.flags[`SET_ADL_TO_PCL]}))
        else $error("More than one ADL source selected");
endmodule

//--- design/cycleSequencer.sv
`include "addrFlags_defs.svh"

module cycleSequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpuPkg::addrMode_t modeIn,
    addrCtrlIf.seq            ctrl,
    output logic              busy,
    output logic              done
);
    assign ctrl.active = busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            ctrl.step <= `STEP_A0;
            ctrl.mode <= cpuPkg::IMPLIED;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                // Starts while busy are dropped
                if (start) begin
                    ctrl.mode <= modeIn;
                    ctrl.step <= `STEP_A0;
                    busy <= 1'b1;
                end
            end else if (ctrl.flags[`END_SEQ]) begin
                busy <= 1'b0;
                done <= 1'b1;
                ctrl.step <= `STEP_A0;
            end else begin
                ctrl.step <= ctrl.step + 2'd1;
            end
        end
    end

    doneOnePulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

    // Every mode must finish by A2
    stepInRange: assert property (@(posedge clk) disable iff (reset)
        busy |-> (ctrl.step <= `STEP_A2))
        else $error("step ran past A2");
endmodule

//--- design/addressingDecoder.sv
`include "addrFlags_defs.svh"

module addressingDecoder (
    addrCtrlIf.dec ctrl
);
    logic useX;

    // Indexed modes differ only in the SB source
    assign useX = (ctrl.mode == cpuPkg::ZPG_X) || (ctrl.mode == cpuPkg::ABS_X);

    always_comb begin
        ctrl.flags = '0;
        if (ctrl.active) begin
            case (ctrl.mode)
                cpuPkg::IMPLIED: begin
                    if (ctrl.step == `STEP_A0) begin
                        ctrl.flags[`END_SEQ] = 1'b1;
                    end
                end
                cpuPkg::IMMEDIATE: begin
                    if (ctrl.step == `STEP_A0) begin
                        ctrl.flags[`LOAD_PC_AB] = 1'b1;
                        ctrl.flags[`PC_INC] = 1'b1;
                        ctrl.flags[`END_SEQ] = 1'b1;
                    end
                end
                cpuPkg::ZPG: begin
                    if (ctrl.step == `STEP_A0) begin
                        ctrl.flags[`SET_ADH_LOW] = 1'b1;
                        ctrl.flags[`SET_ADL_TO_DATA] = 1'b1;
                        ctrl.flags[`LOAD_ABH] = 1'b1;
                        ctrl.flags[`LOAD_ABL] = 1'b1;
                        ctrl.flags[`END_SEQ] = 1'b1;
                    end
                end
                cpuPkg::ZPG_X, cpuPkg::ZPG_Y: begin
                    if (ctrl.step == `STEP_A0) begin
                        // Operand plus index
                        ctrl.flags[`ALU_ADD] = 1'b1;
                        ctrl.flags[`SET_DB_TO_DATA] = 1'b1;
                        ctrl.flags[`SET_INPUT_B_TO_DB] = 1'b1;
                        ctrl.flags[`SET_SB_TO_X] = useX;
                        ctrl.flags[`SET_SB_TO_Y] = !useX;
                        ctrl.flags[`SET_INPUT_A_TO_SB] = 1'b1;
                    end else if (ctrl.step == `STEP_A1) begin
                        // Sum lands in page zero, carry dropped
                        ctrl.flags[`SET_ADH_LOW] = 1'b1;
                        ctrl.flags[`SET_ADL_TO_ALU] = 1'b1;
                        ctrl.flags[`LOAD_ABH] = 1'b1;
                        ctrl.flags[`LOAD_ABL] = 1'b1;
                        ctrl.flags[`END_SEQ] = 1'b1;
                    end
                end
                cpuPkg::ABSOLUTE: begin
                    if (ctrl.step == `STEP_A0) begin
                        ctrl.flags[`PC_INC] = 1'b1;
                        ctrl.flags[`SET_ADL_TO_PCL] = 1'b1;
                        ctrl.flags[`SET_ADH_TO_PCH] = 1'b1;
                        ctrl.flags[`LOAD_ABL] = 1'b1;
                        ctrl.flags[`LOAD_ABH] = 1'b1;
                        ctrl.flags[`SET_DB_TO_DATA] = 1'b1;
                        ctrl.flags[`SET_INPUT_B_TO_DB] = 1'b1;
                    end else if (ctrl.step == `STEP_A1) begin
                        // Low byte from the ALU register, high byte from the bus
                        ctrl.flags[`SET_ADL_TO_ALU] = 1'b1;
                        ctrl.flags[`LOAD_ABL] = 1'b1;
                        ctrl.flags[`SET_DB_TO_DATA] = 1'b1;
                        ctrl.flags[`SET_SB_TO_DB] = 1'b1;
                        ctrl.flags[`SET_ADH_TO_SB] = 1'b1;
                        ctrl.flags[`LOAD_ABH] = 1'b1;
                        ctrl.flags[`END_SEQ] = 1'b1;
                    end
                end
                cpuPkg::ABS_X, cpuPkg::ABS_Y: begin
                    if (ctrl.step == `STEP_A0) begin
                        ctrl.flags[`PC_INC] = 1'b1;
                        ctrl.flags[`SET_ADL_TO_PCL] = 1'b1;
                        ctrl.flags[`SET_ADH_TO_PCH] = 1'b1;
                        ctrl.flags[`LOAD_ABL] = 1'b1;
                        ctrl.flags[`LOAD_ABH] = 1'b1;
                        ctrl.flags[`ALU_ADD] = 1'b1;
                        ctrl.flags[`SET_DB_TO_DATA] = 1'b1;
                        ctrl.flags[`SET_INPUT_B_TO_DB] = 1'b1;
                        ctrl.flags[`SET_SB_TO_X] = useX;
                        ctrl.flags[`SET_SB_TO_Y] = !useX;
                        ctrl.flags[`SET_INPUT_A_TO_SB] = 1'b1;
                    end else if (ctrl.step == `STEP_A1) begin
                        // High byte takes only the low-byte carry
                        ctrl.flags[`SET_ADL_TO_ALU] = 1'b1;
                        ctrl.flags[`LOAD_ABL] = 1'b1;
                        ctrl.flags[`ALU_ADD] = 1'b1;
                        ctrl.flags[`ADD_CARRY] = 1'b1;
                        ctrl.flags[`SET_DB_TO_DATA] = 1'b1;
                        ctrl.flags[`SET_INPUT_B_TO_DB] = 1'b1;
                    end else if (ctrl.step == `STEP_A2) begin
                        ctrl.flags[`SET_SB_TO_ALU] = 1'b1;
                        ctrl.flags[`SET_ADH_TO_SB] = 1'b1;
                        ctrl.flags[`LOAD_ABH] = 1'b1;
                        ctrl.flags[`END_SEQ] = 1'b1;
                    end
                end
            endcase
        end

        assert (!(ctrl.flags[`END_SEQ] && ctrl.flags[`PC_DEC]) &&
                !(ctrl.flags[`SET_ADL_TO_ALU] && ctrl.flags[`SET_ADL_TO_PCL]))
            else $error("Conflicting control flags for mode %0d step %0d",
                        ctrl.mode, ctrl.step);
    end
endmodule

//--- design/addrCtrlIf.sv
`include "addrFlags_defs.svh"

interface addrCtrlIf;
    cpuPkg::addrMode_t     mode;
    logic [1:0]            step;
    logic                  active;
    logic [`NUM_FLAGS-1:0] flags;

    modport seq (
        output mode, step, active,
        input  flags
    );
    modport dec (
        input  mode, step, active,
        output flags
    );
    modport dp (
        input flags
    );
endinterface

//--- design/cpuPkg.sv
package cpuPkg;

    typedef enum logic [2:0] {
        IMPLIED,
        IMMEDIATE,
        ZPG,
        ZPG_X,
        ZPG_Y,
        ABSOLUTE,
        ABS_X,
        ABS_Y
    } addrMode_t;

    typedef struct packed {
        logic [7:0] high;
        logic [7:0] low;
    } addrBytes_t;

    // One address seen whole or by byte
    typedef union packed {
        logic [15:0] word;
        addrBytes_t  bytes;
    } addrWord_t;

endpackage

//--- include/addrFlags_defs.svh
`ifndef ADDRFLAGS_DEFS_SVH
`define ADDRFLAGS_DEFS_SVH

// Width of the datapath control vector
`define NUM_FLAGS 22

// Bus and register controls
`define SET_ADH_LOW        0
`define SET_ADL_TO_DATA    1
`define LOAD_ABL           2
`define LOAD_ABH           3
`define PC_INC             4
`define PC_DEC             5
`define SET_ADL_TO_PCL     6
`define SET_ADH_TO_PCH     7
`define SET_DB_TO_DATA     8
`define SET_INPUT_B_TO_DB  9
`define SET_SB_TO_DB       10
`define SET_ADL_TO_ALU     11
`define SET_ADH_TO_SB      12
`define SET_INPUT_A_TO_SB  13
`define SET_SB_TO_X        14
`define SET_SB_TO_Y        15
`define SET_SB_TO_ACC      16
`define SET_SB_TO_ALU      17
`define ALU_ADD            18

// Adder takes the carry kept from the previous add
`define ADD_CARRY          19
// Last step of the current mode
`define END_SEQ            20
// Address register loads straight from PC
`define LOAD_PC_AB         21

// Step codes
`define STEP_A0 2'b00
`define STEP_A1 2'b01
`define STEP_A2 2'b10

`define PC_RESET 16'h0200

`endif
